// File: src/cce_pkg.sv
// Package of CCE widths, opcodes and the microcode word union that every unit imports
package cce_pkg;

  // Microcode store
  localparam int inst_width_lp      = 32;
  localparam int pc_width_lp        = 6;
  localparam int op_width_lp        = 4;

  // General purpose registers
  localparam int gpr_width_lp       = 16;
  localparam int num_gpr_lp         = 4;
  localparam int gpr_sel_width_lp   = 2;

  // LCE message fields
  localparam int addr_width_lp      = 16;
  localparam int lce_id_width_lp    = 2;
  localparam int cmd_type_width_lp  = 3;

  // Way groups tracked by the pending bits
  localparam int block_offset_lp    = 3;
  localparam int num_way_groups_lp  = 8;
  localparam int way_group_width_lp = $clog2(num_way_groups_lp);

  // Opcodes
  // Unlisted encodings execute as no-ops
  localparam logic [op_width_lp-1:0] op_movi_lp  = 4'd1;
  localparam logic [op_width_lp-1:0] op_add_lp   = 4'd2;
  localparam logic [op_width_lp-1:0] op_sub_lp   = 4'd3;
  localparam logic [op_width_lp-1:0] op_addi_lp  = 4'd4;
  localparam logic [op_width_lp-1:0] op_beq_lp   = 4'd5;
  localparam logic [op_width_lp-1:0] op_bne_lp   = 4'd6;
  localparam logic [op_width_lp-1:0] op_bi_lp    = 4'd7;
  localparam logic [op_width_lp-1:0] op_popq_lp  = 4'd8;
  localparam logic [op_width_lp-1:0] op_pushq_lp = 4'd9;
  localparam logic [op_width_lp-1:0] op_spend_lp = 4'd10;
  localparam logic [op_width_lp-1:0] op_cpend_lp = 4'd11;
  localparam logic [op_width_lp-1:0] op_rdp_lp   = 4'd12;

  // ALU, branch and pending bit format
  typedef struct packed {
    logic [op_width_lp-1:0]      op;
    logic [gpr_sel_width_lp-1:0] dst;
    logic [gpr_sel_width_lp-1:0] src_a;
    logic [gpr_sel_width_lp-1:0] src_b;
    logic [5:0]                  rsvd;
    logic [gpr_width_lp-1:0]     imm;
  } exec_fmt_s;

  // Queue format for popq and pushq
  typedef struct packed {
    logic [op_width_lp-1:0]       op;
    logic [cmd_type_width_lp-1:0] cmd_type;
    logic [gpr_sel_width_lp-1:0]  data_src;
    logic [22:0]                  rsvd;
  } queue_fmt_s;

  // Opcode sits in the same bits in both views
  typedef union packed {
    exec_fmt_s  exec_fmt;
    queue_fmt_s queue_fmt;
  } cce_inst_u;

endpackage

// File: src/cce_fetch.sv
// Fetch stage holding the microcode RAM, the fetch PC and the next-PC predecoder
`timescale 1ns/100ps

module cce_fetch
  (input  logic                                clk_i
   , input  logic                              rst_n_i
   , input  logic                              cfg_run_i
   , input  logic                              cfg_w_v_i
   , input  logic                              cfg_r_v_i
   , input  logic [cce_pkg::pc_width_lp-1:0]   cfg_addr_i
   , input  logic [cce_pkg::inst_width_lp-1:0] cfg_data_i
   , input  logic                              stall_i
   , input  logic                              mispredict_i
   , input  logic [cce_pkg::pc_width_lp-1:0]   resolved_pc_i
   , output cce_pkg::cce_inst_u                inst_o
   , output logic [cce_pkg::pc_width_lp-1:0]   pc_o
   , output logic                              inst_v_o
  );

  import cce_pkg::*;

  logic [inst_width_lp-1:0] ucode_mem [2**pc_width_lp];
  cce_inst_u                inst_q;
  logic [pc_width_lp-1:0]   pc_q;
  logic                     v_q;
  logic [pc_width_lp-1:0]   predicted_pc;
  logic [pc_width_lp-1:0]   next_pc;
  logic [pc_width_lp-1:0]   rd_addr;
  logic                     rd_en;
  logic                     advance;

  // Only bi is predicted taken
  assign predicted_pc = (inst_q.exec_fmt.op == op_bi_lp) ? inst_q.exec_fmt.imm[pc_width_lp-1:0]
                                                          : pc_q + pc_width_lp'(1);

  // First fetch after run rises reads the held PC 0
  assign next_pc = mispredict_i ? resolved_pc_i :
                   !v_q         ? pc_q          : predicted_pc;

  assign advance = cfg_run_i & (~stall_i | mispredict_i);
  assign rd_en   = cfg_run_i ? advance : cfg_r_v_i;
  assign rd_addr = cfg_run_i ? next_pc : cfg_addr_i;

  always_ff @(posedge clk_i) begin
    if (cfg_w_v_i && !cfg_run_i) begin
      ucode_mem[cfg_addr_i] <= cfg_data_i;
    end
  end

  // Also the readback path while idle
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      inst_q <= ucode_mem[rd_addr];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= '0;
      v_q  <= 1'b0;
    end else if (!cfg_run_i) begin
      pc_q <= '0;
      v_q  <= 1'b0;
    end else if (advance) begin
      pc_q <= next_pc;
      v_q  <= 1'b1;
    end
  end

  assign inst_o   = inst_q;
  assign pc_o     = pc_q;
  // Wrong-path word is squashed in the redirect cycle
  assign inst_v_o = v_q & ~mispredict_i;

endmodule

// File: src/cce_decode.sv
// Execute-stage instruction register that decodes the microcode word for the other units
`timescale 1ns/100ps

module cce_decode
  (input  logic                                    clk_i
   , input  logic                                  rst_n_i
   , input  cce_pkg::cce_inst_u                    inst_i
   , input  logic [cce_pkg::pc_width_lp-1:0]       pc_i
   , input  logic                                  inst_v_i
   , input  logic                                  stall_i
   , input  logic                                  mispredict_i
   , output logic                                  ex_v_o
   , output logic [cce_pkg::op_width_lp-1:0]       op_o
   , output logic [cce_pkg::gpr_sel_width_lp-1:0]  dst_o
   , output logic [cce_pkg::gpr_sel_width_lp-1:0]  src_a_o
   , output logic [cce_pkg::gpr_sel_width_lp-1:0]  src_b_o
   , output logic [cce_pkg::gpr_width_lp-1:0]      imm_o
   , output logic [cce_pkg::cmd_type_width_lp-1:0] cmd_type_o
   , output logic [cce_pkg::gpr_sel_width_lp-1:0]  data_src_o
   , output logic [cce_pkg::pc_width_lp-1:0]       ex_pc_o
  );

  import cce_pkg::*;

  cce_inst_u              ex_inst_q;
  logic [pc_width_lp-1:0] ex_pc_q;
  logic                   ex_v_q;
  logic                   is_queue;

  // Branch in execute kills whatever follows it
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_v_q <= 1'b0;
    end else if (mispredict_i) begin
      ex_v_q <= 1'b0;
    end else if (!stall_i) begin
      ex_v_q <= inst_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      ex_inst_q <= inst_i;
      ex_pc_q   <= pc_i;
    end
  end

  assign is_queue = (ex_inst_q.queue_fmt.op == op_popq_lp) ||
                    (ex_inst_q.queue_fmt.op == op_pushq_lp);

  always_comb begin
    op_o       = ex_inst_q.exec_fmt.op;
    dst_o      = '0;
    src_a_o    = '0;
    src_b_o    = '0;
    imm_o      = '0;
    cmd_type_o = '0;
    data_src_o = '0;
    if (is_queue) begin
      cmd_type_o = ex_inst_q.queue_fmt.cmd_type;
      data_src_o = ex_inst_q.queue_fmt.data_src;
    end else begin
      dst_o   = ex_inst_q.exec_fmt.dst;
      src_a_o = ex_inst_q.exec_fmt.src_a;
      src_b_o = ex_inst_q.exec_fmt.src_b;
      imm_o   = ex_inst_q.exec_fmt.imm;
    end
  end

  assign ex_v_o  = ex_v_q;
  assign ex_pc_o = ex_pc_q;

endmodule

// File: src/cce_exec.sv
// Execute datapath with the register file, the ALU and conditional branch resolution
`timescale 1ns/100ps

module cce_exec
  (input  logic                                   clk_i
   , input  logic                                 rst_n_i
   , input  logic                                 ex_v_i
   , input  logic [cce_pkg::op_width_lp-1:0]      op_i
   , input  logic [cce_pkg::gpr_sel_width_lp-1:0] dst_i
   , input  logic [cce_pkg::gpr_sel_width_lp-1:0] src_a_i
   , input  logic [cce_pkg::gpr_sel_width_lp-1:0] src_b_i
   , input  logic [cce_pkg::gpr_width_lp-1:0]     imm_i
   , input  logic [cce_pkg::pc_width_lp-1:0]      ex_pc_i
   , input  logic [cce_pkg::gpr_sel_width_lp-1:0] data_src_i
   , input  logic                                 stall_i
   , input  logic                                 pending_i
   , output logic [cce_pkg::gpr_width_lp-1:0]     data_o
   , output logic                                 mispredict_o
   , output logic [cce_pkg::pc_width_lp-1:0]      resolved_pc_o
  );

  import cce_pkg::*;

  logic [gpr_width_lp-1:0] gpr_q [num_gpr_lp];
  logic [gpr_width_lp-1:0] opd_a;
  logic [gpr_width_lp-1:0] opd_b;
  logic [gpr_width_lp-1:0] wr_data;
  logic                    wr_en;
  logic                    taken;
  logic [pc_width_lp-1:0]  target_pc;

  assign opd_a = gpr_q[src_a_i];
  assign opd_b = gpr_q[src_b_i];

  // ALU ops wrap at 16 bits
  always_comb begin
    wr_en   = 1'b1;
    wr_data = '0;
    case (op_i)
      op_movi_lp: wr_data = imm_i;
      op_add_lp:  wr_data = opd_a + opd_b;
      op_sub_lp:  wr_data = opd_a - opd_b;
      op_addi_lp: wr_data = opd_a + imm_i;
      op_rdp_lp:  wr_data = {{(gpr_width_lp-1){1'b0}}, pending_i};
      default:    wr_en   = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < num_gpr_lp; i++) begin
        gpr_q[i] <= '0;
      end
    end else if (ex_v_i && wr_en && !stall_i) begin
      gpr_q[dst_i] <= wr_data;
    end
  end

  // Fetch assumed not taken for beq and bne
  always_comb begin
    case (op_i)
      op_beq_lp: taken = (opd_a == opd_b);
      op_bne_lp: taken = (opd_a != opd_b);
      default:   taken = 1'b0;
    endcase
  end

  assign target_pc     = imm_i[pc_width_lp-1:0];
  assign mispredict_o  = ex_v_i & taken;
  assign resolved_pc_o = taken ? target_pc : ex_pc_i + pc_width_lp'(1);

  // pushq payload
  assign data_o = gpr_q[data_src_i];

endmodule

// File: src/cce_pending_bits.sv
// One pending bit per way group, set and cleared by microcode and read back combinationally
`timescale 1ns/100ps

module cce_pending_bits
  (input  logic                                clk_i
   , input  logic                              rst_n_i
   , input  logic                              set_i
   , input  logic                              clear_i
   , input  logic [cce_pkg::addr_width_lp-1:0] addr_i
   , output logic                              pending_o
  );

  import cce_pkg::*;

  logic [num_way_groups_lp-1:0]  bits_q;
  logic [way_group_width_lp-1:0] group;

  // Block address modulo the group count
  assign group = way_group_width_lp'((addr_i >> block_offset_lp) % num_way_groups_lp);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bits_q <= '0;
    end else if (set_i) begin
      bits_q[group] <= 1'b1;
    end else if (clear_i) begin
      bits_q[group] <= 1'b0;
    end
  end

  assign pending_o = bits_q[group];

endmodule

// File: src/cce_msg.sv
// Message unit running the LCE request and command handshakes, the MSHR and the queue stall
`timescale 1ns/100ps

module cce_msg
  (input  logic                                    clk_i
   , input  logic                                  rst_n_i
   , input  logic                                  ex_v_i
   , input  logic [cce_pkg::op_width_lp-1:0]       op_i
   , input  logic [cce_pkg::cmd_type_width_lp-1:0] cmd_type_i
   , input  logic [cce_pkg::gpr_width_lp-1:0]      data_i

   // LCE request, valid then yumi
   , input  logic                                  lce_req_v_i
   , input  logic [cce_pkg::addr_width_lp-1:0]     lce_req_addr_i
   , input  logic [cce_pkg::lce_id_width_lp-1:0]   lce_req_lce_i
   , output logic                                  lce_req_yumi_o

   // LCE command, ready then valid
   , output logic                                  lce_cmd_v_o
   , output logic [cce_pkg::cmd_type_width_lp-1:0] lce_cmd_type_o
   , output logic [cce_pkg::addr_width_lp-1:0]     lce_cmd_addr_o
   , output logic [cce_pkg::lce_id_width_lp-1:0]   lce_cmd_lce_o
   , output logic [cce_pkg::gpr_width_lp-1:0]      lce_cmd_data_o
   , input  logic                                  lce_cmd_ready_i

   , output logic [cce_pkg::addr_width_lp-1:0]     mshr_addr_o
   , output logic                                  stall_o
  );

  import cce_pkg::*;

  logic                       pop_v;
  logic                       push_v;
  logic [addr_width_lp-1:0]   mshr_addr_q;
  logic [lce_id_width_lp-1:0] mshr_lce_q;

  assign pop_v  = ex_v_i & (op_i == op_popq_lp);
  assign push_v = ex_v_i & (op_i == op_pushq_lp);

  // Request consumed in the same cycle it is accepted
  assign lce_req_yumi_o = pop_v & lce_req_v_i;
  assign lce_cmd_v_o    = push_v & lce_cmd_ready_i;

  // Queue op waiting on its partner holds the whole pipe
  assign stall_o = (pop_v & ~lce_req_v_i) | (push_v & ~lce_cmd_ready_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mshr_addr_q <= '0;
      mshr_lce_q  <= '0;
    end else if (lce_req_yumi_o) begin
      mshr_addr_q <= lce_req_addr_i;
      mshr_lce_q  <= lce_req_lce_i;
    end
  end

  // Payload only shown on the transfer cycle
  assign lce_cmd_type_o = lce_cmd_v_o ? cmd_type_i  : '0;
  assign lce_cmd_addr_o = lce_cmd_v_o ? mshr_addr_q : '0;
  assign lce_cmd_lce_o  = lce_cmd_v_o ? mshr_lce_q  : '0;
  assign lce_cmd_data_o = lce_cmd_v_o ? data_i      : '0;

  assign mshr_addr_o = mshr_addr_q;

endmodule

// File: src/cce_top.sv
// Top level of the microcoded CCE that wires fetch, decode, execute, pending bits and messages
`timescale 1ns/100ps

module cce_top
  (input  logic                                    clk_i
   , input  logic                                  rst_n_i

   // Microcode load and readback
   , input  logic                                  cfg_run_i
   , input  logic                                  cfg_w_v_i
   , input  logic                                  cfg_r_v_i
   , input  logic [cce_pkg::pc_width_lp-1:0]       cfg_addr_i
   , input  logic [cce_pkg::inst_width_lp-1:0]     cfg_data_i
   , output logic [cce_pkg::inst_width_lp-1:0]     cfg_ucode_data_o

   , input  logic                                  lce_req_v_i
   , input  logic [cce_pkg::addr_width_lp-1:0]     lce_req_addr_i
   , input  logic [cce_pkg::lce_id_width_lp-1:0]   lce_req_lce_i
   , output logic                                  lce_req_yumi_o

   , output logic                                  lce_cmd_v_o
   , output logic [cce_pkg::cmd_type_width_lp-1:0] lce_cmd_type_o
   , output logic [cce_pkg::addr_width_lp-1:0]     lce_cmd_addr_o
   , output logic [cce_pkg::lce_id_width_lp-1:0]   lce_cmd_lce_o
   , output logic [cce_pkg::gpr_width_lp-1:0]      lce_cmd_data_o
   , input  logic                                  lce_cmd_ready_i
  );

  import cce_pkg::*;

  // Fetch to decode
  cce_inst_u                     fetch_inst_lo;
  logic [pc_width_lp-1:0]        fetch_pc_lo;
  logic                          fetch_v_lo;

  // Decoded execute stage
  logic                          ex_v_lo;
  logic [op_width_lp-1:0]        ex_op_lo;
  logic [gpr_sel_width_lp-1:0]   ex_dst_lo;
  logic [gpr_sel_width_lp-1:0]   ex_src_a_lo;
  logic [gpr_sel_width_lp-1:0]   ex_src_b_lo;
  logic [gpr_width_lp-1:0]       ex_imm_lo;
  logic [cmd_type_width_lp-1:0]  ex_cmd_type_lo;
  logic [gpr_sel_width_lp-1:0]   ex_data_src_lo;
  logic [pc_width_lp-1:0]        ex_pc_lo;

  // Execute, message and pending bit results
  logic                          mispredict_lo;
  logic [pc_width_lp-1:0]        resolved_pc_lo;
  logic [gpr_width_lp-1:0]       gpr_data_lo;
  logic                          stall_lo;
  logic [addr_width_lp-1:0]      mshr_addr_lo;
  logic                          pending_lo;
  logic                          pend_set_li;
  logic                          pend_clear_li;

  assign cfg_ucode_data_o = fetch_inst_lo;

  assign pend_set_li   = ex_v_lo & (ex_op_lo == op_spend_lp);
  assign pend_clear_li = ex_v_lo & (ex_op_lo == op_cpend_lp);

  cce_fetch fetch
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.cfg_run_i(cfg_run_i)
     ,.cfg_w_v_i(cfg_w_v_i)
     ,.cfg_r_v_i(cfg_r_v_i)
     ,.cfg_addr_i(cfg_addr_i)
     ,.cfg_data_i(cfg_data_i)
     ,.stall_i(stall_lo)
     ,.mispredict_i(mispredict_lo)
     ,.resolved_pc_i(resolved_pc_lo)
     ,.inst_o(fetch_inst_lo)
     ,.pc_o(fetch_pc_lo)
     ,.inst_v_o(fetch_v_lo)
     );

  cce_decode decode
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.inst_i(fetch_inst_lo)
     ,.pc_i(fetch_pc_lo)
     ,.inst_v_i(fetch_v_lo)
     ,.stall_i(stall_lo)
     ,.mispredict_i(mispredict_lo)
     ,.ex_v_o(ex_v_lo)
     ,.op_o(ex_op_lo)
     ,.dst_o(ex_dst_lo)
     ,.src_a_o(ex_src_a_lo)
     ,.src_b_o(ex_src_b_lo)
     ,.imm_o(ex_imm_lo)
     ,.cmd_type_o(ex_cmd_type_lo)
     ,.data_src_o(ex_data_src_lo)
     ,.ex_pc_o(ex_pc_lo)
     );

  cce_exec exec
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.ex_v_i(ex_v_lo)
     ,.op_i(ex_op_lo)
     ,.dst_i(ex_dst_lo)
     ,.src_a_i(ex_src_a_lo)
     ,.src_b_i(ex_src_b_lo)
     ,.imm_i(ex_imm_lo)
     ,.ex_pc_i(ex_pc_lo)
     ,.data_src_i(ex_data_src_lo)
     ,.stall_i(stall_lo)
     ,.pending_i(pending_lo)
     ,.data_o(gpr_data_lo)
     ,.mispredict_o(mispredict_lo)
     ,.resolved_pc_o(resolved_pc_lo)
     );

  // Indexed by the address held in the MSHR
  cce_pending_bits pending_bits
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.set_i(pend_set_li)
     ,.clear_i(pend_clear_li)
     ,.addr_i(mshr_addr_lo)
     ,.pending_o(pending_lo)
     );

  cce_msg message
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.ex_v_i(ex_v_lo)
     ,.op_i(ex_op_lo)
     ,.cmd_type_i(ex_cmd_type_lo)
     ,.data_i(gpr_data_lo)
     ,.lce_req_v_i(lce_req_v_i)
     ,.lce_req_addr_i(lce_req_addr_i)
     ,.lce_req_lce_i(lce_req_lce_i)
     ,.lce_req_yumi_o(lce_req_yumi_o)
     ,.lce_cmd_v_o(lce_cmd_v_o)
     ,.lce_cmd_type_o(lce_cmd_type_o)
     ,.lce_cmd_addr_o(lce_cmd_addr_o)
     ,.lce_cmd_lce_o(lce_cmd_lce_o)
     ,.lce_cmd_data_o(lce_cmd_data_o)
     ,.lce_cmd_ready_i(lce_cmd_ready_i)
     ,.mshr_addr_o(mshr_addr_lo)
     ,.stall_o(stall_lo)
     );

endmodule

// File: test/cce_properties.sv
// Handshake assertions for the message unit, attached to every cce_msg instance through bind
`timescale 1ns/100ps

module cce_properties
  (input  logic   clk_i
   , input logic  rst_n_i
   , input logic  lce_req_v_i
   , input logic  lce_req_yumi_i
   , input logic  lce_cmd_v_i
   , input logic  lce_cmd_ready_i
  );

  // A request is only taken while it is offered
  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lce_req_yumi_i |-> lce_req_v_i)
    else $error("yumi raised without a valid LCE request");

  cmd_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lce_cmd_v_i |-> lce_cmd_ready_i)
    else $error("LCE command valid raised while the LCE was not ready");

  // popq and pushq never share the execute stage
  no_pop_and_push: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(lce_req_yumi_i && lce_cmd_v_i))
    else $error("yumi and command valid raised in the same cycle");

endmodule

bind cce_msg cce_properties props
  (.clk_i(clk_i)
   ,.rst_n_i(rst_n_i)
   ,.lce_req_v_i(lce_req_v_i)
   ,.lce_req_yumi_i(lce_req_yumi_o)
   ,.lce_cmd_v_i(lce_cmd_v_o)
   ,.lce_cmd_ready_i(lce_cmd_ready_i)
   );

// File: test/tb_cce.sv
// Directed testbench for the CCE, run as top module tb_cce: loads microcode and checks commands
`timescale 1ns/100ps

module tb_cce;

  import cce_pkg::*;

  logic                         clk_i = 1'b0;
  logic                         rst_n_i;
  logic                         cfg_run_i;
  logic                         cfg_w_v_i;
  logic                         cfg_r_v_i;
  logic [pc_width_lp-1:0]       cfg_addr_i;
  logic [inst_width_lp-1:0]     cfg_data_i;
  logic [inst_width_lp-1:0]     cfg_ucode_data_o;
  logic                         lce_req_v_i;
  logic [addr_width_lp-1:0]     lce_req_addr_i;
  logic [lce_id_width_lp-1:0]   lce_req_lce_i;
  logic                         lce_req_yumi_o;
  logic                         lce_cmd_v_o;
  logic [cmd_type_width_lp-1:0] lce_cmd_type_o;
  logic [addr_width_lp-1:0]     lce_cmd_addr_o;
  logic [lce_id_width_lp-1:0]   lce_cmd_lce_o;
  logic [gpr_width_lp-1:0]      lce_cmd_data_o;
  logic                         lce_cmd_ready_i;

  int                           cycle_count = 0;
  logic [inst_width_lp-1:0]     prog_q [$];
  // Type, address, LCE and data of each transfer
  logic [36:0]                  cmd_log [$];

  cce_top DUT
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.cfg_run_i(cfg_run_i)
     ,.cfg_w_v_i(cfg_w_v_i)
     ,.cfg_r_v_i(cfg_r_v_i)
     ,.cfg_addr_i(cfg_addr_i)
     ,.cfg_data_i(cfg_data_i)
     ,.cfg_ucode_data_o(cfg_ucode_data_o)
     ,.lce_req_v_i(lce_req_v_i)
     ,.lce_req_addr_i(lce_req_addr_i)
     ,.lce_req_lce_i(lce_req_lce_i)
     ,.lce_req_yumi_o(lce_req_yumi_o)
     ,.lce_cmd_v_o(lce_cmd_v_o)
     ,.lce_cmd_type_o(lce_cmd_type_o)
     ,.lce_cmd_addr_o(lce_cmd_addr_o)
     ,.lce_cmd_lce_o(lce_cmd_lce_o)
     ,.lce_cmd_data_o(lce_cmd_data_o)
     ,.lce_cmd_ready_i(lce_cmd_ready_i)
     );

  always #5 clk_i = ~clk_i;

  // Each test ends well inside 500 cycles, so six tests with twice that margin
  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= 6000) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycle_count);
      $display("Simulation failed");
      $fatal(1, "run stopped at the cycle limit");
    end
  end

  // Inputs change on the falling edge, so the rising edge sees settled values
  always @(posedge clk_i) begin
    if (lce_cmd_v_o) begin
      cmd_log.push_back({lce_cmd_type_o, lce_cmd_addr_o, lce_cmd_lce_o, lce_cmd_data_o});
    end
  end

  task automatic compare_values(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [15:0] rand16();
    return 16'($urandom);
  endfunction

  function automatic logic [31:0] exec_word(input logic [3:0] op, input logic [1:0] dst,
                                            input logic [1:0] src_a, input logic [1:0] src_b,
                                            input logic [15:0] imm);
    return {op, dst, src_a, src_b, 6'b0, imm};
  endfunction

  function automatic logic [31:0] queue_word(input logic [3:0] op, input logic [2:0] cmd_type,
                                             input logic [1:0] data_src);
    return {op, cmd_type, data_src, 23'b0};
  endfunction

  // bi to its own PC parks the engine once the program is done
  task automatic close_program();
    prog_q.push_back(exec_word(op_bi_lp, 2'd0, 2'd0, 2'd0, 16'(prog_q.size())));
  endtask

  task automatic reset_dut();
    @(negedge clk_i);
    rst_n_i = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;
  endtask

  task automatic load_program();
    foreach (prog_q[i]) begin
      @(negedge clk_i);
      cfg_w_v_i  = 1'b1;
      cfg_addr_i = pc_width_lp'(i);
      cfg_data_i = prog_q[i];
    end
    @(negedge clk_i);
    cfg_w_v_i = 1'b0;
  endtask

  task automatic start_program();
    cmd_log.delete();
    cfg_run_i = 1'b1;
  endtask

  task automatic stop_program();
    @(negedge clk_i);
    cfg_run_i = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic send_request(input int delay, input logic [15:0] addr, input logic [1:0] lce);
    repeat (delay) @(negedge clk_i);
    lce_req_v_i    = 1'b1;
    lce_req_addr_i = addr;
    lce_req_lce_i  = lce;
    do begin
      @(posedge clk_i);
    end while (!lce_req_yumi_o);
    @(negedge clk_i);
    lce_req_v_i    = 1'b0;
    lce_req_addr_i = '0;
    lce_req_lce_i  = '0;
  endtask

  // Waits for n commands, then makes sure nothing else follows
  task automatic collect_commands(input int n, input string name);
    while (cmd_log.size() < n) begin
      @(negedge clk_i);
    end
    repeat (8) @(negedge clk_i);
    compare_values({name, " command count"}, 64'(n), 64'(cmd_log.size()));
  endtask

  task automatic expect_command(input string name, input int idx, input logic [2:0] kind,
                                input logic [15:0] addr, input logic [1:0] lce,
                                input logic [15:0] data);
    compare_values($sformatf("%s command %0d", name, idx), 64'({kind, addr, lce, data}),
                   64'(cmd_log[idx]));
  endtask

  task automatic microcode_readback();
    logic [31:0] words [16];
    for (int i = 0; i < 16; i++) begin
      words[i] = $urandom;
      @(negedge clk_i);
      cfg_w_v_i  = 1'b1;
      cfg_addr_i = 6'(i * 4 + 1);
      cfg_data_i = words[i];
    end
    @(negedge clk_i);
    cfg_w_v_i = 1'b0;
    for (int i = 0; i < 16; i++) begin
      cfg_r_v_i  = 1'b1;
      cfg_addr_i = 6'(i * 4 + 1);
      @(negedge clk_i);
      cfg_r_v_i = 1'b0;
      compare_values($sformatf("readback %0d", i), 64'(words[i]), 64'(cfg_ucode_data_o));
    end
  endtask

  task automatic arithmetic_program();
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] c;
    a = rand16();
    b = rand16();
    c = rand16();
    reset_dut();
    prog_q.delete();
    prog_q.push_back(exec_word(op_movi_lp, 2'd0, 2'd0, 2'd0, a));
    prog_q.push_back(exec_word(op_movi_lp, 2'd1, 2'd0, 2'd0, b));
    prog_q.push_back(exec_word(op_add_lp, 2'd2, 2'd0, 2'd1, 16'd0));
    prog_q.push_back(exec_word(op_sub_lp, 2'd3, 2'd0, 2'd1, 16'd0));
    prog_q.push_back(exec_word(op_addi_lp, 2'd1, 2'd1, 2'd0, c));
    for (int r = 0; r < 4; r++) begin
      prog_q.push_back(queue_word(op_pushq_lp, 3'd5, 2'(r)));
    end
    close_program();
    load_program();
    start_program();
    collect_commands(4, "arithmetic");
    // MSHR still holds its reset value
    expect_command("arithmetic", 0, 3'd5, 16'd0, 2'd0, a);
    expect_command("arithmetic", 1, 3'd5, 16'd0, 2'd0, b + c);
    expect_command("arithmetic", 2, 3'd5, 16'd0, 2'd0, a + b);
    expect_command("arithmetic", 3, 3'd5, 16'd0, 2'd0, a - b);
    stop_program();
  endtask

  task automatic request_to_command();
    logic [15:0] data;
    logic [15:0] addr;
    logic [1:0]  lce;
    logic [2:0]  kind;
    data = rand16();
    kind = 3'($urandom);
    reset_dut();
    prog_q.delete();
    prog_q.push_back(exec_word(op_movi_lp, 2'd0, 2'd0, 2'd0, data));
    prog_q.push_back(queue_word(op_popq_lp, 3'd0, 2'd0));
    prog_q.push_back(queue_word(op_pushq_lp, kind, 2'd0));
    close_program();
    load_program();
    for (int round = 0; round < 4; round++) begin
      addr = rand16();
      lce  = 2'($urandom);
      start_program();
      send_request(int'($urandom_range(15)), addr, lce);
      collect_commands(1, "request");
      expect_command("request", 0, kind, addr, lce, data);
      stop_program();
    end
  endtask

  task automatic cmd_backpressure();
    logic [15:0] d1;
    logic [15:0] d2;
    logic [15:0] addr;
    logic [1:0]  lce;
    int          hold;
    d1   = rand16();
    d2   = rand16();
    addr = rand16();
    lce  = 2'($urandom);
    hold = int'($urandom_range(20, 5));
    reset_dut();
    lce_cmd_ready_i = 1'b0;
    prog_q.delete();
    prog_q.push_back(exec_word(op_movi_lp, 2'd1, 2'd0, 2'd0, d1));
    prog_q.push_back(exec_word(op_movi_lp, 2'd2, 2'd0, 2'd0, d2));
    prog_q.push_back(queue_word(op_popq_lp, 3'd0, 2'd0));
    prog_q.push_back(queue_word(op_pushq_lp, 3'd1, 2'd1));
    prog_q.push_back(queue_word(op_pushq_lp, 3'd6, 2'd2));
    close_program();
    load_program();
    start_program();
    send_request(2, addr, lce);
    repeat (hold) @(negedge clk_i);
    compare_values("backpressure held", 64'd0, 64'(cmd_log.size()));
    lce_cmd_ready_i = 1'b1;
    collect_commands(2, "backpressure");
    expect_command("backpressure", 0, 3'd1, addr, lce, d1);
    expect_command("backpressure", 1, 3'd6, addr, lce, d2);
    stop_program();
  endtask

  task automatic branch_loop();
    int          n;
    logic [15:0] marker;
    n      = 3 + int'($urandom_range(5));
    marker = rand16() | 16'h8000;
    reset_dut();
    prog_q.delete();
    prog_q.push_back(exec_word(op_movi_lp, 2'd0, 2'd0, 2'd0, 16'd0));
    prog_q.push_back(exec_word(op_movi_lp, 2'd1, 2'd0, 2'd0, 16'(n)));
    prog_q.push_back(exec_word(op_movi_lp, 2'd2, 2'd0, 2'd0, marker));
    // Loop top at PC 3
    prog_q.push_back(exec_word(op_addi_lp, 2'd0, 2'd0, 2'd0, 16'd1));
    prog_q.push_back(exec_word(op_bne_lp, 2'd0, 2'd0, 2'd1, 16'd7));
    // Fetched behind every taken bne, executed only on the last pass
    prog_q.push_back(queue_word(op_pushq_lp, 3'd3, 2'd0));
    prog_q.push_back(exec_word(op_bi_lp, 2'd0, 2'd0, 2'd0, 16'd9));
    // Reached only from the bne, skipped by the bi above
    prog_q.push_back(queue_word(op_pushq_lp, 3'd3, 2'd0));
    prog_q.push_back(exec_word(op_bi_lp, 2'd0, 2'd0, 2'd0, 16'd3));
    prog_q.push_back(queue_word(op_pushq_lp, 3'd3, 2'd2));
    close_program();
    load_program();
    start_program();
    collect_commands(n + 1, "branch");
    for (int i = 0; i < n; i++) begin
      expect_command("branch", i, 3'd3, 16'd0, 2'd0, 16'(i + 1));
    end
    expect_command("branch", n, 3'd3, 16'd0, 2'd0, marker);
    stop_program();
  endtask

  task automatic pending_bit_program();
    logic [15:0] a1;
    logic [15:0] a2;
    logic [1:0]  l1;
    logic [1:0]  l2;
    a1 = rand16();
    a2 = rand16();
    // Bits 5:3 pick the way group, so a2 lands in another one
    a2[5:3] = a1[5:3] ^ 3'(1 + $urandom_range(6));
    l1 = 2'($urandom);
    l2 = 2'($urandom);
    reset_dut();
    prog_q.delete();
    prog_q.push_back(queue_word(op_popq_lp, 3'd0, 2'd0));
    prog_q.push_back(exec_word(op_spend_lp, 2'd0, 2'd0, 2'd0, 16'd0));
    prog_q.push_back(exec_word(op_rdp_lp, 2'd0, 2'd0, 2'd0, 16'd0));
    prog_q.push_back(queue_word(op_pushq_lp, 3'd4, 2'd0));
    prog_q.push_back(exec_word(op_cpend_lp, 2'd0, 2'd0, 2'd0, 16'd0));
    prog_q.push_back(exec_word(op_rdp_lp, 2'd1, 2'd0, 2'd0, 16'd0));
    prog_q.push_back(queue_word(op_pushq_lp, 3'd4, 2'd1));
    prog_q.push_back(exec_word(op_spend_lp, 2'd0, 2'd0, 2'd0, 16'd0));
    prog_q.push_back(queue_word(op_popq_lp, 3'd0, 2'd0));
    prog_q.push_back(exec_word(op_rdp_lp, 2'd2, 2'd0, 2'd0, 16'd0));
    prog_q.push_back(queue_word(op_pushq_lp, 3'd4, 2'd2));
    close_program();
    load_program();
    start_program();
    send_request(int'($urandom_range(6)), a1, l1);
    send_request(int'($urandom_range(6)), a2, l2);
    collect_commands(3, "pending");
    expect_command("pending", 0, 3'd4, a1, l1, 16'd1);
    expect_command("pending", 1, 3'd4, a1, l1, 16'd0);
    expect_command("pending", 2, 3'd4, a2, l2, 16'd0);
    stop_program();
  endtask

  initial begin
    void'($urandom(63));
    rst_n_i         = 1'b0;
    cfg_run_i       = 1'b0;
    cfg_w_v_i       = 1'b0;
    cfg_r_v_i       = 1'b0;
    cfg_addr_i      = '0;
    cfg_data_i      = '0;
    lce_req_v_i     = 1'b0;
    lce_req_addr_i  = '0;
    lce_req_lce_i   = '0;
    lce_cmd_ready_i = 1'b1;
    reset_dut();
    microcode_readback();
    arithmetic_program();
    request_to_command();
    cmd_backpressure();
    branch_loop();
    pending_bit_program();
    $display("Simulation passed");
    $finish;
  end

endmodule

// File: filelist.f
src/cce_pkg.sv
src/cce_fetch.sv
src/cce_decode.sv
src/cce_exec.sv
src/cce_pending_bits.sv
src/cce_msg.sv
src/cce_top.sv
test/cce_properties.sv
test/tb_cce.sv

// File: Makefile
# Verilator build and run of the CCE testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_cce -f filelist.f
	./obj_dir/Vtb_cce

clean:
	rm -rf obj_dir
